// ==== source/ex_pkg.sv ====
// Shared widths and opcodes for the execute stage assume a 32-bit integer data path only
package ex_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Default integer data path width
  localparam int DATA_WIDTH = 32;

  // Register address width for the ALU and load write ports
  localparam int REG_ADDR_WIDTH = 6;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  // ALU operations
  // Compare results come back as a one-bit truth, zero-extended
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    // Set-less-than
    ALU_SLTS,
    ALU_SLTU,
    // Branch compares
    ALU_EQ,
    ALU_NE,
    ALU_LTS,
    ALU_GES,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Multiplier operations
  // Only the low product and the unsigned high product exist
  typedef enum logic {
    MUL_LOW,
    MUL_HIGHU
  } mult_op_e;

endpackage

// ==== source/ex_alu.sv ====
// Purely combinational integer ALU with no shifts, and compares are valid only for compare opcodes
module ex_alu
  import ex_pkg::*;
#(
  parameter int DATA_WIDTH = ex_pkg::DATA_WIDTH
) (
  input  alu_op_e               operator_i,
  input  logic [DATA_WIDTH-1:0] operand_a_i,
  input  logic [DATA_WIDTH-1:0] operand_b_i,
  output logic [DATA_WIDTH-1:0] result_o,
  output logic                  cmp_result_o
);

  logic                  sub_en;
  logic [DATA_WIDTH-1:0] adder_b;
  logic [DATA_WIDTH:0]   adder_sum;
  logic                  is_equal;
  logic                  is_less_u;
  logic                  is_less_s;

  //////////////////////////////
  // Shared adder
  //////////////////////////////

  // Everything except ADD runs the adder as a - b
  assign sub_en  = (operator_i != ALU_ADD);
  assign adder_b = sub_en ? ~operand_b_i : operand_b_i;

  // Extra top bit holds the carry out
  assign adder_sum = {1'b0, operand_a_i} + {1'b0, adder_b} + (DATA_WIDTH+1)'(sub_en);

  //////////////////////////////
  // Comparison unit
  //////////////////////////////

  assign is_equal = (operand_a_i == operand_b_i);

  // No carry out of a - b means a borrow, so a < b unsigned
  assign is_less_u = ~adder_sum[DATA_WIDTH];

  // Differing signs decide directly
  // otherwise the sign of the difference does
  assign is_less_s = (operand_a_i[DATA_WIDTH-1] ^ operand_b_i[DATA_WIDTH-1]) ?
                     operand_a_i[DATA_WIDTH-1] : adder_sum[DATA_WIDTH-1];

  // Truth of the selected test, also the branch decision
  always_comb begin
    case (operator_i)
      ALU_EQ:   cmp_result_o = is_equal;
      ALU_NE:   cmp_result_o = ~is_equal;
      ALU_LTS,
      ALU_SLTS: cmp_result_o = is_less_s;
      ALU_GES:  cmp_result_o = ~is_less_s;
      ALU_LTU,
      ALU_SLTU: cmp_result_o = is_less_u;
      ALU_GEU:  cmp_result_o = ~is_less_u;
      default:  cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////
  // Result mux
  //////////////////////////////

  always_comb begin
    case (operator_i)
      ALU_ADD,
      ALU_SUB: result_o = adder_sum[DATA_WIDTH-1:0];
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      // Set-less-than and compares give a zero-extended flag
      default: result_o = DATA_WIDTH'(cmp_result_o);
    endcase
  end

endmodule

// ==== source/ex_mult.sv ====
// Iterative unsigned multiplier takes DATA_WIDTH+1 cycles and needs operands held until done
module ex_mult
  import ex_pkg::*;
#(
  parameter int DATA_WIDTH = ex_pkg::DATA_WIDTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable_i,
  input  mult_op_e              operator_i,
  input  logic [DATA_WIDTH-1:0] op_a_i,
  input  logic [DATA_WIDTH-1:0] op_b_i,
  input  logic                  ex_ready_i,
  output logic [DATA_WIDTH-1:0] result_o,
  output logic                  ready_o,
  output logic                  multicycle_o
);

  localparam int CNT_WIDTH = $clog2(DATA_WIDTH);

  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } mult_state_e;

  mult_state_e             state_q;
  mult_state_e             state_d;
  logic [CNT_WIDTH-1:0]    count_q;
  logic                    last_bit;
  mult_op_e                op_q;
  logic [DATA_WIDTH-1:0]   mcand_q;
  logic [DATA_WIDTH-1:0]   mplier_q;
  logic [DATA_WIDTH-1:0]   acc_q;
  logic [DATA_WIDTH-1:0]   result_q;
  logic [DATA_WIDTH:0]     acc_sum;
  logic [2*DATA_WIDTH-1:0] prod_next;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  assign last_bit = (count_q == CNT_WIDTH'(DATA_WIDTH - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (enable_i) state_d = BUSY;
      BUSY: if (last_bit) state_d = DONE;
      // Result stays put until the stage moves on
      DONE: if (ex_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      // One multiplier bit per BUSY cycle
      if (state_q == BUSY) begin
        count_q <= count_q + CNT_WIDTH'(1);
      end else begin
        count_q <= '0;
      end
    end
  end

  //////////////////////////////
  // Shift-add datapath
  //////////////////////////////

  // Add the multiplicand when the current multiplier bit is set
  assign acc_sum = mplier_q[0] ? ({1'b0, acc_q} + {1'b0, mcand_q}) : {1'b0, acc_q};

  // Carry and sum shift right into the multiplier register
  assign prod_next = {acc_sum, mplier_q[DATA_WIDTH-1:1]};

  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && enable_i) begin
      mcand_q  <= op_a_i;
      mplier_q <= op_b_i;
      acc_q    <= '0;
      op_q     <= operator_i;
    end else if (state_q == BUSY) begin
      acc_q    <= prod_next[2*DATA_WIDTH-1:DATA_WIDTH];
      mplier_q <= prod_next[DATA_WIDTH-1:0];
      // Pick the requested half on the final step
      if (last_bit) begin
        result_q <= (op_q == MUL_HIGHU) ? prod_next[2*DATA_WIDTH-1:DATA_WIDTH] :
                                          prod_next[DATA_WIDTH-1:0];
      end
    end
  end

  // Ready when idle with no request, or holding a result
  assign ready_o      = (state_q == DONE) | ((state_q == IDLE) & ~enable_i);
  assign multicycle_o = (state_q == DONE);
  assign result_o     = result_q;

endmodule

// ==== source/ex_writeback.sv ====
// Forward mux and EX/WB load register assume one write per port per cycle with no contention
module ex_writeback
  import ex_pkg::*;
#(
  parameter int DATA_WIDTH     = ex_pkg::DATA_WIDTH,
  parameter int REG_ADDR_WIDTH = ex_pkg::REG_ADDR_WIDTH
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // Unit enables
  input  logic                      alu_en_i,
  input  logic                      mult_en_i,
  input  logic                      csr_access_i,
  input  logic                      lsu_en_i,
  // Unit results
  input  logic [DATA_WIDTH-1:0]     alu_result_i,
  input  logic [DATA_WIDTH-1:0]     mult_result_i,
  input  logic [DATA_WIDTH-1:0]     csr_rdata_i,
  input  logic [DATA_WIDTH-1:0]     lsu_rdata_i,
  // Write requests
  input  logic                      regfile_alu_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] regfile_alu_waddr_i,
  input  logic                      regfile_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] regfile_waddr_i,
  // Stall inputs
  input  logic                      mult_ready_i,
  input  logic                      lsu_ready_ex_i,
  input  logic                      lsu_err_i,
  input  logic                      wb_ready_i,
  input  logic                      branch_in_ex_i,
  // Forward port
  output logic                      regfile_alu_we_fw_o,
  output logic [REG_ADDR_WIDTH-1:0] regfile_alu_waddr_fw_o,
  output logic [DATA_WIDTH-1:0]     regfile_alu_wdata_fw_o,
  // Load port
  output logic                      regfile_we_wb_o,
  output logic [REG_ADDR_WIDTH-1:0] regfile_waddr_wb_o,
  output logic [DATA_WIDTH-1:0]     regfile_wdata_wb_o,
  // Handshake
  output logic                      ex_ready_o,
  output logic                      ex_valid_o
);

  logic stall_free;
  logic unit_active;
  logic load_we;

  //////////////////////////////
  // Forward write port
  //////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR wins over multiplier, multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  //////////////////////////////
  // Stage handshake
  //////////////////////////////

  assign stall_free  = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign unit_active = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Branches resolve here and never wait on WB
  assign ex_ready_o = stall_free | branch_in_ex_i;
  // Valid never looks at ready
  assign ex_valid_o = unit_active & stall_free;

  //////////////////////////////
  // EX/WB load register
  //////////////////////////////

  // A faulting load must not write the register file
  assign load_we = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_wb_o <= 1'b0;
    end else if (ex_valid_o) begin
      regfile_we_wb_o <= load_we;
    end else if (wb_ready_i) begin
      // WB drained and nothing new arrived
      regfile_we_wb_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && load_we) begin
      regfile_waddr_wb_o <= regfile_waddr_i;
    end
  end

  // Load data comes straight from the LSU
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

// ==== source/ex_stage.sv ====
// Execute stage top for integer ALU, multiply and CSR only, with ID inputs arriving decoded
module ex_stage
  import ex_pkg::*;
#(
  parameter int DATA_WIDTH     = ex_pkg::DATA_WIDTH,
  parameter int REG_ADDR_WIDTH = ex_pkg::REG_ADDR_WIDTH
) (
  input  logic                      clk,
  input  logic                      rst_n,
  // ALU operands from ID
  input  alu_op_e                   alu_operator_i,
  input  logic [DATA_WIDTH-1:0]     alu_operand_a_i,
  input  logic [DATA_WIDTH-1:0]     alu_operand_b_i,
  input  logic [DATA_WIDTH-1:0]     alu_operand_c_i,
  input  logic                      alu_en_i,
  // Multiplier operands from ID
  input  mult_op_e                  mult_operator_i,
  input  logic [DATA_WIDTH-1:0]     mult_operand_a_i,
  input  logic [DATA_WIDTH-1:0]     mult_operand_b_i,
  input  logic                      mult_en_i,
  // CSR and LSU data
  input  logic                      csr_access_i,
  input  logic [DATA_WIDTH-1:0]     csr_rdata_i,
  input  logic                      lsu_en_i,
  input  logic [DATA_WIDTH-1:0]     lsu_rdata_i,
  input  logic                      branch_in_ex_i,
  // Write requests
  input  logic                      regfile_alu_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] regfile_alu_waddr_i,
  input  logic                      regfile_we_i,
  input  logic [REG_ADDR_WIDTH-1:0] regfile_waddr_i,
  // Stall control
  input  logic                      lsu_ready_ex_i,
  input  logic                      lsu_err_i,
  input  logic                      wb_ready_i,
  output logic                      mult_multicycle_o,
  // To IF
  output logic                      branch_decision_o,
  output logic [DATA_WIDTH-1:0]     jump_target_o,
  // Write ports
  output logic                      regfile_alu_we_fw_o,
  output logic [REG_ADDR_WIDTH-1:0] regfile_alu_waddr_fw_o,
  output logic [DATA_WIDTH-1:0]     regfile_alu_wdata_fw_o,
  output logic                      regfile_we_wb_o,
  output logic [REG_ADDR_WIDTH-1:0] regfile_waddr_wb_o,
  output logic [DATA_WIDTH-1:0]     regfile_wdata_wb_o,
  output logic                      ex_ready_o,
  output logic                      ex_valid_o
);

  logic [DATA_WIDTH-1:0] alu_result;
  logic                  alu_cmp_result;
  logic [DATA_WIDTH-1:0] mult_result;
  logic                  mult_ready;

  // Branch decision from the compare, target from operand C
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  //////////////////////////////
  // Processing units
  //////////////////////////////

  ex_alu #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  ex_mult #(
    .DATA_WIDTH (DATA_WIDTH)
  ) u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  //////////////////////////////
  // Output side
  //////////////////////////////

  ex_writeback #(
    .DATA_WIDTH     (DATA_WIDTH),
    .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
  ) u_writeback (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .lsu_en_i               (lsu_en_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .mult_ready_i           (mult_ready),
    .lsu_ready_ex_i         (lsu_ready_ex_i),
    .lsu_err_i              (lsu_err_i),
    .wb_ready_i             (wb_ready_i),
    .branch_in_ex_i         (branch_in_ex_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o),
    .ex_ready_o             (ex_ready_o),
    .ex_valid_o             (ex_valid_o)
  );

endmodule

// ==== dv/ex_tb_clk.sv ====
// Testbench clock and reset only, reset is released on a rising edge after RESET_CYCLES cycles
module ex_tb_clk #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD/2) clk_o = ~clk_o;
  end

  // Reset held low for the first RESET_CYCLES rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// ==== dv/ex_stage_tb.sv ====
// Table-driven testbench for the execute stage, 32-bit data assumed, one multiply in flight at a time
module ex_stage_tb
  import ex_pkg::*;
;

  localparam int          PERIOD       = 20;
  localparam int          DRIVE_DELAY  = 2;
  localparam int          SAMPLE_DELAY = 8;
  localparam logic [31:0] SEED         = 32'h03fe_1d4e;

  typedef enum logic [2:0] {
    K_ALU, K_BRANCH, K_MUL, K_CSR, K_LOAD, K_LOAD_ERR, K_STALL
  } row_kind_e;

  logic                      clk;
  logic                      rst_n;
  alu_op_e                   alu_operator;
  logic [DATA_WIDTH-1:0]     alu_operand_a;
  logic [DATA_WIDTH-1:0]     alu_operand_b;
  logic [DATA_WIDTH-1:0]     alu_operand_c;
  logic                      alu_en;
  mult_op_e                  mult_operator;
  logic [DATA_WIDTH-1:0]     mult_operand_a;
  logic [DATA_WIDTH-1:0]     mult_operand_b;
  logic                      mult_en;
  logic                      csr_access;
  logic [DATA_WIDTH-1:0]     csr_rdata;
  logic                      lsu_en;
  logic [DATA_WIDTH-1:0]     lsu_rdata;
  logic                      branch_in_ex;
  logic                      regfile_alu_we;
  logic [REG_ADDR_WIDTH-1:0] regfile_alu_waddr;
  logic                      regfile_we;
  logic [REG_ADDR_WIDTH-1:0] regfile_waddr;
  logic                      lsu_ready_ex;
  logic                      lsu_err;
  logic                      wb_ready;
  logic                      mult_multicycle;
  logic                      branch_decision;
  logic [DATA_WIDTH-1:0]     jump_target;
  logic                      regfile_alu_we_fw;
  logic [REG_ADDR_WIDTH-1:0] regfile_alu_waddr_fw;
  logic [DATA_WIDTH-1:0]     regfile_alu_wdata_fw;
  logic                      regfile_we_wb;
  logic [REG_ADDR_WIDTH-1:0] regfile_waddr_wb;
  logic [DATA_WIDTH-1:0]     regfile_wdata_wb;
  logic                      ex_ready;
  logic                      ex_valid;

  // Stimulus table kept as one queue per column
  row_kind_e             kind_q[$];
  logic [3:0]            op_q[$];
  logic [DATA_WIDTH-1:0] a_q[$];
  logic [DATA_WIDTH-1:0] b_q[$];
  logic [DATA_WIDTH-1:0] c_q[$];
  logic [DATA_WIDTH-1:0] exp_q[$];

  int word_errors = 0;
  int addr_errors = 0;
  int bit_errors  = 0;
  int cycle_count = 0;
  int cycle_limit = 1000;

  ex_tb_clk #(.PERIOD(PERIOD), .RESET_CYCLES(4)) u_clk (.clk_o(clk), .rst_n_o(rst_n));

  ex_stage #(
    .DATA_WIDTH     (DATA_WIDTH),
    .REG_ADDR_WIDTH (REG_ADDR_WIDTH)
  ) DUT (
    .clk (clk), .rst_n (rst_n),
    .alu_operator_i (alu_operator), .alu_operand_a_i (alu_operand_a),
    .alu_operand_b_i (alu_operand_b), .alu_operand_c_i (alu_operand_c), .alu_en_i (alu_en),
    .mult_operator_i (mult_operator), .mult_operand_a_i (mult_operand_a),
    .mult_operand_b_i (mult_operand_b), .mult_en_i (mult_en),
    .csr_access_i (csr_access), .csr_rdata_i (csr_rdata),
    .lsu_en_i (lsu_en), .lsu_rdata_i (lsu_rdata), .branch_in_ex_i (branch_in_ex),
    .regfile_alu_we_i (regfile_alu_we), .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i (regfile_we), .regfile_waddr_i (regfile_waddr),
    .lsu_ready_ex_i (lsu_ready_ex), .lsu_err_i (lsu_err), .wb_ready_i (wb_ready),
    .mult_multicycle_o (mult_multicycle), .branch_decision_o (branch_decision),
    .jump_target_o (jump_target),
    .regfile_alu_we_fw_o (regfile_alu_we_fw), .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw),
    .regfile_we_wb_o (regfile_we_wb), .regfile_waddr_wb_o (regfile_waddr_wb),
    .regfile_wdata_wb_o (regfile_wdata_wb),
    .ex_ready_o (ex_ready), .ex_valid_o (ex_valid)
  );

  //////////////////////////////
  // Reference model and helpers
  //////////////////////////////

  function automatic logic [31:0] next_random(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Integer ALU rules where compares give a zero-extended truth
  function automatic logic [DATA_WIDTH-1:0] alu_model(input alu_op_e op,
      input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
    logic lts;
    logic ltu;
    lts = ($signed(a) < $signed(b));
    ltu = (a < b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLTS, ALU_LTS: return DATA_WIDTH'(lts);
      ALU_SLTU, ALU_LTU: return DATA_WIDTH'(ltu);
      ALU_EQ:   return DATA_WIDTH'(a == b);
      ALU_NE:   return DATA_WIDTH'(a != b);
      ALU_GES:  return DATA_WIDTH'(!lts);
      default:  return DATA_WIDTH'(!ltu);
    endcase
  endfunction

  // Low or high half of the unsigned full product
  function automatic logic [DATA_WIDTH-1:0] mul_model(input logic high,
      input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b);
    logic [2*DATA_WIDTH-1:0] prod;
    prod = {{DATA_WIDTH{1'b0}}, a} * {{DATA_WIDTH{1'b0}}, b};
    return high ? prod[2*DATA_WIDTH-1:DATA_WIDTH] : prod[DATA_WIDTH-1:0];
  endfunction

  task automatic add_row(input row_kind_e kind, input logic [3:0] op,
      input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
      input logic [DATA_WIDTH-1:0] c, input logic [DATA_WIDTH-1:0] exp);
    kind_q.push_back(kind);
    op_q.push_back(op);
    a_q.push_back(a);
    b_q.push_back(b);
    c_q.push_back(c);
    exp_q.push_back(exp);
  endtask

  task automatic check_word(input logic [DATA_WIDTH-1:0] got,
      input logic [DATA_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      word_errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input logic [REG_ADDR_WIDTH-1:0] got,
      input logic [REG_ADDR_WIDTH-1:0] exp, input string what);
    if (got !== exp) begin
      addr_errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      bit_errors++;
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Inputs change a little after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic idle_inputs();
    alu_operator = ALU_ADD;
    {alu_operand_a, alu_operand_b, alu_operand_c, alu_en} = '0;
    mult_operator = MUL_LOW;
    {mult_operand_a, mult_operand_b, mult_en} = '0;
    {csr_access, csr_rdata, lsu_en, lsu_rdata, branch_in_ex} = '0;
    {regfile_alu_we, regfile_alu_waddr, regfile_we, regfile_waddr} = '0;
    lsu_ready_ex = 1'b1;
    lsu_err      = 1'b0;
    wb_ready     = 1'b1;
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: no finish after %0d clock cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    row_kind_e             kind;
    logic [3:0]            op;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [DATA_WIDTH-1:0] c;
    logic [DATA_WIDTH-1:0] exp;
    logic [31:0]           rng;
    int                    waits;
    idle_inputs();
    // Fixed rows
    add_row(K_ALU, ALU_ADD, 32'h7fff_ffff, 32'h0000_0001, 32'h05, 32'h8000_0000);
    add_row(K_ALU, ALU_SUB, 32'h0000_0005, 32'h0000_0007, 32'h06, 32'hffff_fffe);
    add_row(K_ALU, ALU_AND, 32'hf0f0_ff00, 32'h0ff0_f0f0, 32'h07, 32'h00f0_f000);
    add_row(K_ALU, ALU_OR, 32'hf0f0_0000, 32'h0000_0f0f, 32'h08, 32'hf0f0_0f0f);
    add_row(K_ALU, ALU_XOR, 32'hffff_0000, 32'h0f0f_0f0f, 32'h09, 32'hf0f0_0f0f);
    add_row(K_ALU, ALU_SLTS, 32'hffff_ffff, 32'h0000_0001, 32'h0a, 32'h0000_0001);
    add_row(K_ALU, ALU_SLTU, 32'hffff_ffff, 32'h0000_0001, 32'h0b, 32'h0000_0000);
    add_row(K_BRANCH, ALU_EQ, 32'h0000_1234, 32'h0000_1234, 32'h0000_0100, 32'd1);
    add_row(K_BRANCH, ALU_NE, 32'h0000_1234, 32'h0000_1234, 32'h0000_0200, 32'd0);
    add_row(K_BRANCH, ALU_LTS, 32'h8000_0000, 32'h0000_0001, 32'h0000_0300, 32'd1);
    add_row(K_BRANCH, ALU_GES, 32'h8000_0000, 32'h0000_0001, 32'h0000_0400, 32'd0);
    add_row(K_BRANCH, ALU_LTU, 32'h8000_0000, 32'h0000_0001, 32'h0000_0500, 32'd0);
    add_row(K_BRANCH, ALU_GEU, 32'h8000_0000, 32'h0000_0001, 32'h0000_0600, 32'd1);
    add_row(K_MUL, 4'(MUL_LOW), 32'hffff_ffff, 32'hffff_ffff, 32'h0c, 32'h0000_0001);
    add_row(K_MUL, 4'(MUL_HIGHU), 32'hffff_ffff, 32'hffff_ffff, 32'h0d, 32'hffff_fffe);
    add_row(K_CSR, 4'd0, 32'hdead_beef, 32'd0, 32'h0e, 32'hdead_beef);
    add_row(K_LOAD, 4'd0, 32'hcafe_f00d, 32'd0, 32'h2a, 32'd1);
    add_row(K_LOAD_ERR, 4'd0, 32'h1234_5678, 32'd0, 32'h15, 32'd0);
    add_row(K_STALL, 4'd0, 32'h0bad_f00d, 32'd0, 32'h11, 32'd1);
    // Random rows cover each ALU opcode and each multiply opcode once
    rng = SEED;
    for (op = 4'd0; op <= ALU_GEU; op++) begin
      rng = next_random(rng);
      a   = rng;
      rng = next_random(rng);
      b   = rng;
      rng = next_random(rng);
      exp = alu_model(alu_op_e'(op), a, b);
      if (op >= ALU_EQ) add_row(K_BRANCH, op, a, b, rng, exp);
      else add_row(K_ALU, op, a, b, {26'd0, rng[5:0]}, exp);
    end
    for (int h = 0; h < 2; h++) begin
      rng = next_random(rng);
      a   = rng;
      rng = next_random(rng);
      b   = rng;
      add_row(K_MUL, 4'(h), a, b, 32'h1f, mul_model(h[0], a, b));
    end
    cycle_limit = kind_q.size() * (DATA_WIDTH + 8) + 20;

    // Reset values before the first active edge
    wait (rst_n === 1'b1);
    #SAMPLE_DELAY;
    check_bit(regfile_we_wb, 1'b0, "regfile_we_wb after reset");
    check_bit(mult_multicycle, 1'b0, "mult_multicycle after reset");

    foreach (kind_q[i]) begin
      kind = kind_q[i];
      op   = op_q[i];
      a    = a_q[i];
      b    = b_q[i];
      c    = c_q[i];
      exp  = exp_q[i];
      next_cycle();
      idle_inputs();
      case (kind)
        K_ALU, K_BRANCH: begin
          alu_operator      = alu_op_e'(op);
          alu_operand_a     = a;
          alu_operand_b     = b;
          alu_operand_c     = c;
          alu_en            = 1'b1;
          regfile_alu_we    = (kind == K_ALU);
          regfile_alu_waddr = c[REG_ADDR_WIDTH-1:0];
          // Branches resolve even while WB stalls
          branch_in_ex      = (kind == K_BRANCH);
          wb_ready          = (kind == K_ALU);
          #SAMPLE_DELAY;
          if (kind == K_ALU) begin
            check_word(regfile_alu_wdata_fw, exp, "ALU forward data");
            check_addr(regfile_alu_waddr_fw, c[REG_ADDR_WIDTH-1:0], "ALU forward address");
            check_bit(regfile_alu_we_fw, 1'b1, "ALU forward write enable");
            check_bit(ex_valid, 1'b1, "ex_valid on ALU row");
          end else begin
            check_bit(branch_decision, exp[0], "branch decision");
            check_word(jump_target, c, "jump target");
            check_bit(ex_ready, 1'b1, "ex_ready on branch with WB stalled");
          end
        end
        K_MUL: begin
          mult_operator     = mult_op_e'(op[0]);
          mult_operand_a    = a;
          mult_operand_b    = b;
          mult_en           = 1'b1;
          // ALU also enabled so the multiplier must win the forward port
          alu_en            = 1'b1;
          regfile_alu_we    = 1'b1;
          regfile_alu_waddr = c[REG_ADDR_WIDTH-1:0];
          #SAMPLE_DELAY;
          check_bit(ex_ready, 1'b0, "ex_ready in first multiply cycle");
          // Bounded by the watchdog
          waits = 0;
          while (ex_valid !== 1'b1) begin
            next_cycle();
            #SAMPLE_DELAY;
            waits++;
          end
          check_word(DATA_WIDTH'(waits), DATA_WIDTH'(DATA_WIDTH + 1), "multiply latency");
          check_word(regfile_alu_wdata_fw, exp, "multiply result");
          check_bit(mult_multicycle, 1'b1, "mult_multicycle in result cycle");
        end
        K_CSR: begin
          csr_access     = 1'b1;
          csr_rdata      = a;
          // ALU also enabled so the CSR must win the forward port
          alu_en         = 1'b1;
          regfile_alu_we = 1'b1;
          #SAMPLE_DELAY;
          check_word(regfile_alu_wdata_fw, exp, "CSR forward data");
        end
        K_LOAD, K_LOAD_ERR: begin
          lsu_en        = 1'b1;
          lsu_rdata     = a;
          regfile_we    = 1'b1;
          regfile_waddr = c[REG_ADDR_WIDTH-1:0];
          lsu_err       = (kind == K_LOAD_ERR);
          #SAMPLE_DELAY;
          check_word(regfile_wdata_wb, a, "load write data");
          next_cycle();
          idle_inputs();
          #SAMPLE_DELAY;
          check_bit(regfile_we_wb, exp[0], "load write enable");
          if (exp[0]) check_addr(regfile_waddr_wb, c[REG_ADDR_WIDTH-1:0], "load address");
        end
        default: begin
          // Load first and stall WB for the next two cycles
          lsu_en        = 1'b1;
          lsu_rdata     = a;
          regfile_we    = 1'b1;
          regfile_waddr = c[REG_ADDR_WIDTH-1:0];
          next_cycle();
          idle_inputs();
          alu_en         = 1'b1;
          regfile_alu_we = 1'b1;
          wb_ready       = 1'b0;
          #SAMPLE_DELAY;
          check_bit(ex_valid, 1'b0, "ex_valid while WB stalled");
          check_bit(ex_ready, 1'b0, "ex_ready while WB stalled");
          check_bit(regfile_we_wb, 1'b1, "load write enable before stall");
          next_cycle();
          #SAMPLE_DELAY;
          check_bit(regfile_we_wb, exp[0], "load write enable held in stall");
          check_addr(regfile_waddr_wb, c[REG_ADDR_WIDTH-1:0], "load address held in stall");
        end
      endcase
    end

    $display("Errors: word %0d, address %0d, flag %0d over %0d rows",
             word_errors, addr_errors, bit_errors, kind_q.size());
    if (word_errors + addr_errors + bit_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
source/ex_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_writeback.sv
source/ex_stage.sv
dv/ex_tb_clk.sv
dv/ex_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module ex_stage_tb -o ex_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/ex_stage_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Test passed$"; then
  exit 0
fi
echo "Pass message not found"
exit 1
